// ==== Makefile ====
TOP = tb_dist_tree

.PHONY: sim clean

# build and run, then look for the pass line in the log
sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/dist_config_ctrl.sv ====
`include "dist_defines.svh"

module dist_config_ctrl import dist_pkg::*; (
	input  logic                           clk,
	input  logic                           i_reset,

	// wishbone classic slave
	input  logic                           i_wb_cyc,
	input  logic                           i_wb_stb,
	input  logic                           i_wb_we,
	input  logic [`DIST_WB_ADDR_WIDTH-1:0] i_wb_adr,
	input  logic [`DIST_WB_DATA_WIDTH-1:0] i_wb_dat,
	output logic [`DIST_WB_DATA_WIDTH-1:0] o_wb_dat,
	output logic                           o_wb_ack,

	// leaf valids fed back for counting
	input  logic [`DIST_NUM_LEAVES-1:0]    i_leaf_valid,

	// switch controls
	output logic                           o_en,
	output dist_cmd_e                      o_cmd_root,
	output dist_cmd_e                      o_cmd_low,
	output dist_cmd_e                      o_cmd_high
);

	// bus handshake
	logic                           wb_req;
	logic                           ack_next;
	logic                           r_wait;
	logic                           wr_stb;

	// decoded register access
	logic                           cfg_wr;
	logic [`DIST_NUM_LEAVES-1:0]    cnt_clr;
	logic [`DIST_WB_DATA_WIDTH-1:0] rd_data;

	// configuration fields
	logic                           r_en;
	dist_cmd_e                      r_cmd_root;
	dist_cmd_e                      r_cmd_low;
	dist_cmd_e                      r_cmd_high;

	// per-leaf delivery counters
	logic [`DIST_CNT_WIDTH-1:0]     r_cnt [`DIST_NUM_LEAVES];

	//////////////////////////////
	// wishbone handshake
	//////////////////////////////

	assign wb_req = i_wb_cyc & i_wb_stb;

	// r_wait holds off a second ack while stb stays up
	// cleared by one cycle of stb low
	assign ack_next = wb_req & ~r_wait;
	assign wr_stb   = ack_next & i_wb_we;

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			o_wb_ack <= 1'b0;
			r_wait   <= 1'b0;
		end
		else
		begin
			o_wb_ack <= ack_next;
			r_wait   <= wb_req & (r_wait | ack_next);
		end
	end

	//////////////////////////////
	// address decode
	//////////////////////////////

	always_comb
	begin
		cfg_wr  = 1'b0;
		cnt_clr = '0;
		rd_data = '0;
		case (i_wb_adr)
			REG_CONFIG:
			begin
				cfg_wr  = wr_stb;
				// en at bit 0, then root, low child, high child
				rd_data = {{(`DIST_WB_DATA_WIDTH - 1 - 3*`DIST_CMD_WIDTH){1'b0}},
					r_cmd_high, r_cmd_low, r_cmd_root, r_en};
			end
			REG_CNT_LEAF0, REG_CNT_LEAF1, REG_CNT_LEAF2, REG_CNT_LEAF3:
			begin
				// counters sit at 4..7, low two bits pick the leaf
				cnt_clr[i_wb_adr[1:0]] = wr_stb;
				rd_data = {{(`DIST_WB_DATA_WIDTH - `DIST_CNT_WIDTH){1'b0}},
					r_cnt[i_wb_adr[1:0]]};
			end
			// holes read zero, writes dropped
			default: rd_data = '0;
		endcase
	end

	// read data lands together with ack
	always_ff @(posedge clk)
	begin
		if (ack_next)
			o_wb_dat <= rd_data;
	end

	//////////////////////////////
	// configuration register
	//////////////////////////////

	// new setting active from the ack edge on
	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			r_en       <= 1'b0;
			r_cmd_root <= CMD_NONE;
			r_cmd_low  <= CMD_NONE;
			r_cmd_high <= CMD_NONE;
		end
		else if (cfg_wr)
		begin
			r_en       <= i_wb_dat[0];
			r_cmd_root <= dist_cmd_e'(i_wb_dat[1 +: `DIST_CMD_WIDTH]);
			r_cmd_low  <= dist_cmd_e'(i_wb_dat[1 + `DIST_CMD_WIDTH +: `DIST_CMD_WIDTH]);
			r_cmd_high <= dist_cmd_e'(i_wb_dat[1 + 2*`DIST_CMD_WIDTH +: `DIST_CMD_WIDTH]);
		end
	end

	assign o_en       = r_en;
	assign o_cmd_root = r_cmd_root;
	assign o_cmd_low  = r_cmd_low;
	assign o_cmd_high = r_cmd_high;

	//////////////////////////////
	// leaf counters
	//////////////////////////////

	// one count per cycle with the leaf valid high
	// a clear in the same cycle beats the increment
	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			for (int k = 0; k < `DIST_NUM_LEAVES; k++)
				r_cnt[k] <= '0;
		end
		else
		begin
			for (int k = 0; k < `DIST_NUM_LEAVES; k++)
			begin
				if (cnt_clr[k])
					r_cnt[k] <= '0;
				else if (i_leaf_valid[k])
					r_cnt[k] <= r_cnt[k] + 1'b1;    // wraps
			end
		end
	end

endmodule

// ==== design/dist_defines.svh ====
`ifndef DIST_DEFINES_SVH
`define DIST_DEFINES_SVH

// payload word carried through every switch
`define DIST_DATA_WIDTH 32

// per-switch command, one enable bit per output
`define DIST_CMD_WIDTH 2

// wishbone slave port
// word address, 8 registers
`define DIST_WB_ADDR_WIDTH 3
`define DIST_WB_DATA_WIDTH 32

// leaf delivery counters, free running and wrapping
`define DIST_CNT_WIDTH 16

// four leaves behind a two-level tree
`define DIST_NUM_LEAVES 4

`endif

// ==== design/dist_pkg.sv ====
`include "dist_defines.svh"

package dist_pkg;

	//////////////////////////////
	// switch commands
	//////////////////////////////

	// bit 0 opens the low output, bit 1 the high output
	typedef enum logic [`DIST_CMD_WIDTH-1:0]
	{
		CMD_NONE        = 2'b00,
		CMD_BRANCH_LOW  = 2'b01,
		CMD_BRANCH_HIGH = 2'b10,
		CMD_DUPLICATE   = 2'b11
	} dist_cmd_e;

	//////////////////////////////
	// register map
	//////////////////////////////

	// addresses 1..3 are holes, they read zero
	typedef enum logic [`DIST_WB_ADDR_WIDTH-1:0]
	{
		REG_CONFIG    = 3'd0,
		REG_CNT_LEAF0 = 3'd4,
		REG_CNT_LEAF1 = 3'd5,
		REG_CNT_LEAF2 = 3'd6,
		REG_CNT_LEAF3 = 3'd7
	} dist_reg_e;

endpackage

// ==== design/dist_tree_top.sv ====
`include "dist_defines.svh"

module dist_tree_top import dist_pkg::*; (
	input  logic                                           clk,
	input  logic                                           i_reset,

	// data input
	input  logic                                           i_valid,
	input  logic [`DIST_DATA_WIDTH-1:0]                    i_data,

	// leaf outputs, leaf 0 in the low word
	output logic [`DIST_NUM_LEAVES-1:0]                    o_leaf_valid,
	output logic [`DIST_NUM_LEAVES*`DIST_DATA_WIDTH-1:0]   o_leaf_data,

	// wishbone classic slave
	input  logic                                           i_wb_cyc,
	input  logic                                           i_wb_stb,
	input  logic                                           i_wb_we,
	input  logic [`DIST_WB_ADDR_WIDTH-1:0]                 i_wb_adr,
	input  logic [`DIST_WB_DATA_WIDTH-1:0]                 i_wb_dat,
	output logic [`DIST_WB_DATA_WIDTH-1:0]                 o_wb_dat,
	output logic                                           o_wb_ack
);

	// shared switch controls
	logic                          sw_en;
	dist_cmd_e                     cmd_root;
	dist_cmd_e                     cmd_low;
	dist_cmd_e                     cmd_high;

	// root stage outputs, high child in the upper word
	logic [1:0]                    root_valid;
	logic [2*`DIST_DATA_WIDTH-1:0] root_data;

	//////////////////////////////
	// control and register block
	//////////////////////////////

	dist_config_ctrl u_ctrl (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_we      (i_wb_we),
		.i_wb_adr     (i_wb_adr),
		.i_wb_dat     (i_wb_dat),
		.o_wb_dat     (o_wb_dat),
		.o_wb_ack     (o_wb_ack),
		.i_leaf_valid (o_leaf_valid),
		.o_en         (sw_en),
		.o_cmd_root   (cmd_root),
		.o_cmd_low    (cmd_low),
		.o_cmd_high   (cmd_high)
	);

	//////////////////////////////
	// level 1, root
	//////////////////////////////

	distribute_1x2_seq #(
		.DATA_WIDTH (`DIST_DATA_WIDTH)
	) u_root (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_valid    (i_valid),
		.i_data_bus (i_data),
		.i_en       (sw_en),
		.i_cmd      (cmd_root),
		.o_valid    (root_valid),
		.o_data_bus (root_data)
	);

	//////////////////////////////
	// level 2, children
	//////////////////////////////

	// low child drives leaf 0 and leaf 1
	distribute_1x2_seq #(
		.DATA_WIDTH (`DIST_DATA_WIDTH)
	) u_low (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_valid    (root_valid[0]),
		.i_data_bus (root_data[0 +: `DIST_DATA_WIDTH]),
		.i_en       (sw_en),
		.i_cmd      (cmd_low),
		.o_valid    (o_leaf_valid[1:0]),
		.o_data_bus (o_leaf_data[0 +: 2*`DIST_DATA_WIDTH])
	);

	// high child drives leaf 2 and leaf 3
	distribute_1x2_seq #(
		.DATA_WIDTH (`DIST_DATA_WIDTH)
	) u_high (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_valid    (root_valid[1]),
		.i_data_bus (root_data[`DIST_DATA_WIDTH +: `DIST_DATA_WIDTH]),
		.i_en       (sw_en),
		.i_cmd      (cmd_high),
		.o_valid    (o_leaf_valid[3:2]),
		.o_data_bus (o_leaf_data[2*`DIST_DATA_WIDTH +: 2*`DIST_DATA_WIDTH])
	);

endmodule

// ==== design/distribute_1x2_comb.sv ====
`include "dist_defines.svh"

module distribute_1x2_comb import dist_pkg::*; #(
	parameter int DATA_WIDTH = `DIST_DATA_WIDTH
)(
	// data in
	input  logic                    i_valid,
	input  logic [DATA_WIDTH-1:0]   i_data_bus,

	// control
	input  logic                    i_en,
	input  dist_cmd_e               i_cmd,

	// data out, high output in the upper word
	output logic [1:0]              o_valid,
	output logic [2*DATA_WIDTH-1:0] o_data_bus
);

	// per-branch valid straight from each mux
	logic [1:0]              mux_valid;

	// input word on top, zeros below
	// so a command bit of 1 passes the word
	logic [2*DATA_WIDTH-1:0] mux_in;

	assign mux_in = {i_data_bus, {DATA_WIDTH{1'b0}}};

	//////////////////////////////
	// low branch
	//////////////////////////////

	mux_2x1_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_mux_low (
		.i_valid    (i_valid),
		.i_data_bus (mux_in),
		.i_en       (i_en),
		.i_cmd      (i_cmd[0]),
		.o_valid    (mux_valid[0]),
		.o_data_bus (o_data_bus[0 +: DATA_WIDTH])
	);

	//////////////////////////////
	// high branch
	//////////////////////////////

	mux_2x1_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_mux_high (
		.i_valid    (i_valid),
		.i_data_bus (mux_in),
		.i_en       (i_en),
		.i_cmd      (i_cmd[1]),
		.o_valid    (mux_valid[1]),
		.o_data_bus (o_data_bus[DATA_WIDTH +: DATA_WIDTH])
	);

	// mux valid ignores the command, so gate it here
	// 00 none, 01 low, 10 high, 11 both
	assign o_valid[0] = i_cmd[0] & mux_valid[0];
	assign o_valid[1] = i_cmd[1] & mux_valid[1];

endmodule

// ==== design/distribute_1x2_seq.sv ====
`include "dist_defines.svh"

module distribute_1x2_seq import dist_pkg::*; #(
	parameter int DATA_WIDTH = `DIST_DATA_WIDTH
)(
	input  logic                    clk,
	input  logic                    i_reset,

	// data in
	input  logic                    i_valid,
	input  logic [DATA_WIDTH-1:0]   i_data_bus,

	// control
	input  logic                    i_en,
	input  dist_cmd_e               i_cmd,

	// registered outputs, high output in the upper word
	output logic [1:0]              o_valid,
	output logic [2*DATA_WIDTH-1:0] o_data_bus
);

	// switch result before the stage register
	logic [1:0]              comb_valid;
	logic [2*DATA_WIDTH-1:0] comb_data;

	distribute_1x2_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_switch (
		.i_valid    (i_valid),
		.i_data_bus (i_data_bus),
		.i_en       (i_en),
		.i_cmd      (i_cmd),
		.o_valid    (comb_valid),
		.o_data_bus (comb_data)
	);

	//////////////////////////////
	// pipeline stage
	//////////////////////////////

	// loads every clock, no stall path
	// one new item per cycle per level
	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			o_valid    <= '0;
			o_data_bus <= '0;
		end
		else
		begin
			o_valid    <= comb_valid;
			o_data_bus <= comb_data;
		end
	end

endmodule

// ==== design/mux_2x1_comb.sv ====
`include "dist_defines.svh"

module mux_2x1_comb #(
	parameter int DATA_WIDTH = `DIST_DATA_WIDTH
)(
	// data in, two candidate words side by side
	input  logic                    i_valid,
	input  logic [2*DATA_WIDTH-1:0] i_data_bus,

	// control
	input  logic                    i_en,
	input  logic                    i_cmd,

	// data out
	output logic                    o_valid,
	output logic [DATA_WIDTH-1:0]   o_data_bus
);

	// item is live only while the switch is on
	logic pass;

	assign pass = i_en & i_valid;

	// valid follows the input only when enabled
	assign o_valid = pass;

	// cmd 1 picks the upper word, cmd 0 the lower one
	// dummy data is all zeros
	always_comb
	begin
		if (!pass)
			o_data_bus = '0;
		else if (i_cmd)
			o_data_bus = i_data_bus[DATA_WIDTH +: DATA_WIDTH];
		else
			o_data_bus = i_data_bus[0 +: DATA_WIDTH];
	end

endmodule

// ==== sim.f ====
+incdir+design
design/dist_pkg.sv
design/mux_2x1_comb.sv
design/distribute_1x2_comb.sv
design/distribute_1x2_seq.sv
design/dist_config_ctrl.sv
design/dist_tree_top.sv
test/tb_dist_tree.sv

// ==== test/tb_dist_tree.sv ====
`include "dist_defines.svh"

module tb_dist_tree import dist_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int dw          = `DIST_DATA_WIDTH;
	localparam int num_entries = 8;

	//////////////////////////////
	// stimulus table
	//////////////////////////////

	// config word {high child, low child, root, enable}
	localparam logic [6:0] tab_cfg [num_entries] = '{
		{CMD_DUPLICATE,   CMD_DUPLICATE,   CMD_DUPLICATE,   1'b1},
		{CMD_NONE,        CMD_BRANCH_LOW,  CMD_BRANCH_LOW,  1'b1},
		{CMD_BRANCH_HIGH, CMD_DUPLICATE,   CMD_BRANCH_HIGH, 1'b1},
		{CMD_BRANCH_LOW,  CMD_BRANCH_HIGH, CMD_DUPLICATE,   1'b1},
		{CMD_NONE,        CMD_NONE,        CMD_DUPLICATE,   1'b1},
		{CMD_DUPLICATE,   CMD_DUPLICATE,   CMD_NONE,        1'b1},
		{CMD_DUPLICATE,   CMD_DUPLICATE,   CMD_DUPLICATE,   1'b0},
		{CMD_BRANCH_HIGH, CMD_BRANCH_LOW,  CMD_BRANCH_LOW,  1'b0}
	};
	// items sent back to back per entry
	localparam int tab_items [num_entries] = '{6, 2, 2, 3, 2, 2, 3, 2};
	// leaves that must see each item
	// leaf 0 in bit 0
	localparam logic [3:0] tab_mask [num_entries] = '{
		4'b1111, 4'b0001, 4'b1000, 4'b0110, 4'b0000, 4'b0000, 4'b0000, 4'b0000
	};

	logic                                         clk;
	logic                                         i_reset;
	logic                                         i_valid;
	logic [dw-1:0]                                i_data;
	logic [`DIST_NUM_LEAVES-1:0]                  o_leaf_valid;
	logic [`DIST_NUM_LEAVES*dw-1:0]               o_leaf_data;
	logic                                         i_wb_cyc;
	logic                                         i_wb_stb;
	logic                                         i_wb_we;
	logic [`DIST_WB_ADDR_WIDTH-1:0]               i_wb_adr;
	logic [`DIST_WB_DATA_WIDTH-1:0]               i_wb_dat;
	logic [`DIST_WB_DATA_WIDTH-1:0]               o_wb_dat;
	logic                                         o_wb_ack;

	// scoreboard state
	int          mismatches;
	int          timeouts;
	int          exp_cnt [`DIST_NUM_LEAVES];
	logic [31:0] lfsr_state;

	dist_tree_top UUT (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.o_leaf_valid (o_leaf_valid),
		.o_leaf_data  (o_leaf_data),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_we      (i_wb_we),
		.i_wb_adr     (i_wb_adr),
		.i_wb_dat     (i_wb_dat),
		.o_wb_dat     (o_wb_dat),
		.o_wb_ack     (o_wb_ack)
	);

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Fail at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
			mismatches++;
		end
	endtask

	// galois lfsr on x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		else
			return state >> 1;
	endfunction

	// one lfsr step per data bit
	task automatic random_word(output logic [dw-1:0] word);
		for (int b = 0; b < dw; b++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			word[b] = lfsr_state[0];
		end
	endtask

	// single wishbone classic access
	// bounded wait for ack
	task automatic bus_cycle(input logic we, input logic [`DIST_WB_ADDR_WIDTH-1:0] adr,
		input logic [31:0] wdat, output logic [31:0] rdat);
		logic got_ack;
		got_ack = 1'b0;
		rdat = '0;
		@(posedge clk);
		#1;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = we;
		i_wb_adr = adr;
		i_wb_dat = wdat;
		for (int n = 0; n < 20 && !got_ack; n++)
		begin
			@(posedge clk);
			#1;
			got_ack = o_wb_ack;
		end
		if (got_ack)
			rdat = o_wb_dat;
		else
		begin
			$display("Timeout: no Wishbone acknowledge for address %0d", adr);
			timeouts++;
		end
		// drop the strobe right after ack
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
	endtask

	// every leaf carries the word or shows zeros
	task automatic check_leaves(input logic [3:0] mask, input logic [dw-1:0] word);
		for (int k = 0; k < `DIST_NUM_LEAVES; k++)
		begin
			check(32'(o_leaf_valid[k]), 32'(mask[k]), $sformatf("leaf %0d valid", k));
			check(o_leaf_data[k*dw +: dw], mask[k] ? word : '0,
				$sformatf("leaf %0d data", k));
		end
	endtask

	// configure and then stream the items
	// each item checked two edges after it enters
	task automatic run_entry(input int e);
		logic [dw-1:0] words [8];
		logic [dw-1:0] w;
		logic [31:0]   rd;
		int            n;
		n = tab_items[e];
		bus_cycle(1'b1, REG_CONFIG, 32'(tab_cfg[e]), rd);
		bus_cycle(1'b0, REG_CONFIG, '0, rd);
		check(rd, 32'(tab_cfg[e]), "config readback");
		for (int j = 0; j < n + 2; j++)
		begin
			@(posedge clk);
			#1;
			if (j >= 2)
			begin
				check_leaves(tab_mask[e], words[j-2]);
				for (int k = 0; k < `DIST_NUM_LEAVES; k++)
					exp_cnt[k] += int'(tab_mask[e][k]);
			end
			else
				check_leaves(4'b0000, '0);
			if (j < n)
			begin
				random_word(w);
				words[j] = w;
				i_valid  = 1'b1;
				i_data   = w;
			end
			else
			begin
				i_valid = 1'b0;
				i_data  = '0;
			end
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial
	begin
		logic [31:0] rd;
		mismatches = 0;
		timeouts   = 0;
		lfsr_state = 32'h4cfa_651e;
		for (int k = 0; k < `DIST_NUM_LEAVES; k++)
			exp_cnt[k] = 0;
		i_reset  = 1'b1;
		i_valid  = 1'b0;
		i_data   = '0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		repeat (5) @(posedge clk);
		#1;
		i_reset = 1'b0;

		// reset state
		check(32'(o_leaf_valid), 32'h0, "leaf valids after reset");
		check(32'(o_wb_ack), 32'h0, "ack after reset");
		bus_cycle(1'b0, REG_CONFIG, '0, rd);
		check(rd, 32'h0, "config after reset");
		for (int k = 0; k < `DIST_NUM_LEAVES; k++)
		begin
			bus_cycle(1'b0, 3'(4 + k), '0, rd);
			check(rd, 32'h0, $sformatf("leaf %0d counter after reset", k));
		end

		// routing, back to back and disabled cases
		for (int e = 0; e < num_entries; e++)
			run_entry(e);

		// counters match prediction and then clear
		for (int k = 0; k < `DIST_NUM_LEAVES; k++)
		begin
			bus_cycle(1'b0, 3'(4 + k), '0, rd);
			check(rd, 32'(exp_cnt[k]), $sformatf("leaf %0d counter", k));
			bus_cycle(1'b1, 3'(4 + k), 32'hffff_ffff, rd);
			bus_cycle(1'b0, 3'(4 + k), '0, rd);
			check(rd, 32'h0, $sformatf("leaf %0d counter after clear", k));
		end

		// holes in the map
		for (int a = 1; a < 4; a++)
		begin
			bus_cycle(1'b0, 3'(a), '0, rd);
			check(rd, 32'h0, $sformatf("unmapped address %0d", a));
		end

		$display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
